// File: bench/spi_master_tb.sv
// Testbench of the SPI master.
// Drives the Wishbone port on falling clock edges, attaches a mode 0
// slave model to the SPI pins and checks reset values, registers,
// random transfers, status, interrupt, dropped sends and unmapped reads.

module spi_master_tb
	import spi_reg_pkg::*, spi_core_pkg::*;
();

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 16;
	localparam int NUM_TRANSFERS = 20;
	localparam int SPI_DIVIDER   = 3;
	// 21 transfers of about 70 bus cycles come to roughly 1500 cycles
	localparam int TIMEOUT_CYCLES = 5000;

	logic                    clk = 1'b0;
	logic                    reset;
	logic [WB_ADR_WIDTH-1:0] wb_adr_i;
	logic [WB_DAT_WIDTH-1:0] wb_dat_i;
	logic                    wb_we_i;
	logic [WB_SEL_WIDTH-1:0] wb_sel_i;
	logic                    wb_stb_i;
	logic [WB_DAT_WIDTH-1:0] wb_dat_o;
	logic                    wb_ack_o;
	logic                    spi_cs_n_o;
	logic                    spi_clk_o;
	logic                    spi_mosi_o;
	logic                    spi_miso_i;
	logic                    irq_o;
	int                      slave_count;
	logic [7:0]              slave_byte;
	int                      check_count = 0;
	int                      error_count = 0;
	int                      cycle_count = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	spi_master dut_i (.*);

	spi_slave_model slave_i (
		.spi_cs_n_i   (spi_cs_n_o),
		.spi_clk_i    (spi_clk_o),
		.spi_mosi_i   (spi_mosi_o),
		.spi_miso_o   (spi_miso_i),
		.byte_count_o (slave_count),
		.last_byte_o  (slave_byte)
	);

	// ----------------------------------------
	// Checking and bus tasks
	// ----------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Single-cycle access that starts and ends on a falling edge
	task automatic bus_access(input logic we, input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [WB_DAT_WIDTH-1:0] data, output logic [WB_DAT_WIDTH-1:0] rdata);
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = data;
		wb_sel_i = '1;
		wb_stb_i = 1'b1;
		#(CLK_PERIOD / 4);
		check_value("wb_ack_o", 32'(1'b1), 32'(wb_ack_o));
		rdata = wb_dat_o;
		@(negedge clk);
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic bus_write(input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [WB_DAT_WIDTH-1:0] data);
		logic [WB_DAT_WIDTH-1:0] discard;
		bus_access(1'b1, adr, data, discard);
	endtask

	task automatic read_check(input string name, input logic [WB_ADR_WIDTH-1:0] adr,
			input logic [WB_DAT_WIDTH-1:0] expected);
		logic [WB_DAT_WIDTH-1:0] rdata;
		bus_access(1'b0, adr, '0, rdata);
		check_value(name, expected, rdata);
	endtask

	// Poll STATUS once per cycle until busy drops
	// first is the number of cycles since the SEND edge at the first poll
	task automatic wait_idle(input int first);
		logic [WB_DAT_WIDTH-1:0] status;
		int k;
		int high;
		k = first;
		high = 0;
		bus_access(1'b0, STATUS, '0, status);
		while (status[0]) begin
			check_value("STATUS rx_full while busy", 0, 32'(status[1]));
			check_value("irq_o while busy", 0, 32'(irq_o));
			if (spi_clk_o) begin
				high++;
			end else if (high != 0) begin
				check_value("spi_clk_o high cycles", SPI_DIVIDER + 1, high);
				high = 0;
			end
			k++;
			bus_access(1'b0, STATUS, '0, status);
		end
		// 16 half periods of divider plus 1 cycles
		check_value("busy cycles", 16 * (SPI_DIVIDER + 1), k);
		check_value("STATUS as busy drops", 0, status);
	endtask

	// One transfer, optionally followed by a SEND that hits a busy engine
	task automatic transfer(input logic [7:0] data, input logic [7:0] expected_rx,
			input bit extra_send);
		int count_before;
		count_before = slave_count;
		bus_write(SEND, 32'(data));
		if (extra_send) begin
			bus_write(SEND, 32'(data) ^ 32'hFF);
		end
		wait_idle(extra_send ? 1 : 0);
		read_check("STATUS after transfer", STATUS, 32'h2);
		check_value("irq_o after transfer", 32'(1'b1), 32'(irq_o));
		read_check("RECV", RECV, 32'(expected_rx));
		read_check("STATUS after RECV", STATUS, 0);
		check_value("irq_o after RECV", 0, 32'(irq_o));
		check_value("slave byte count", count_before + 1, slave_count);
		check_value("slave byte", 32'(data), 32'(slave_byte));
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		logic [7:0] sent;
		logic [7:0] prev;
		void'($urandom(92810));
		reset    = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i  = 1'b0;
		wb_sel_i = '0;
		wb_stb_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset values
		check_value("spi_cs_n_o", 32'(1'b1), 32'(spi_cs_n_o));
		check_value("irq_o", 0, 32'(irq_o));
		check_value("spi_clk_o", 0, 32'(spi_clk_o));
		check_value("spi_mosi_o", 0, 32'(spi_mosi_o));
		read_check("STATUS after reset", STATUS, 0);
		read_check("DIVIDER after reset", DIVIDER, 32'd100);

		// Register writes
		bus_write(DIVIDER, 32'h0000_1234);
		read_check("DIVIDER readback", DIVIDER, 32'h0000_1234);
		bus_write(CONTROL, 32'h0);
		check_value("spi_cs_n_o", 0, 32'(spi_cs_n_o));
		read_check("CONTROL readback", CONTROL, 0);
		bus_write(CONTROL, 32'h1);
		check_value("spi_cs_n_o", 32'(1'b1), 32'(spi_cs_n_o));
		bus_write(DIVIDER, SPI_DIVIDER);
		bus_write(CONTROL, 32'h0);

		// RECV returns the byte that the slave echoes from the previous transfer
		prev = '0;
		for (int i = 0; i < NUM_TRANSFERS; i++) begin
			sent = 8'($urandom);
			transfer(sent, prev, 1'b0);
			prev = sent;
		end
		sent = 8'($urandom);
		transfer(sent, prev, 1'b1);

		// Unmapped addresses
		for (int a = 5; a < 8; a++) begin
			read_check("unmapped read", 3'(a), 0);
		end
		check_value("wb_ack_o without strobe", 0, 32'(wb_ack_o));

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Run limit
	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d errors, the tests did not finish",
			cycle_count, error_count);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: bench/spi_slave_model.sv
// Mode 0 SPI slave for the SPI master testbench.
// Shifts out the byte it received in the previous transfer, MSB first,
// and reports how many bytes it has received and the last one.

module spi_slave_model (
	input  logic       spi_cs_n_i,
	input  logic       spi_clk_i,
	input  logic       spi_mosi_i,
	output logic       spi_miso_o,
	output int         byte_count_o,
	output logic [7:0] last_byte_o
);

	logic [7:0] rx_shift = '0;
	logic [7:0] tx_shift = '0;
	logic [7:0] last_q   = '0;
	logic [2:0] bit_cnt  = '0;
	int         count_q  = 0;
	logic [7:0] rx_next;

	assign rx_next      = {rx_shift[6:0], spi_mosi_i};
	assign spi_miso_o   = tx_shift[7];
	assign byte_count_o = count_q;
	assign last_byte_o  = last_q;

	// MOSI sampled on the rising edge
	always @(posedge spi_clk_i) begin
		if (!spi_cs_n_i) begin
			rx_shift <= rx_next;
			bit_cnt  <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				last_q  <= rx_next;
				count_q <= count_q + 1;
			end
		end
	end

	// Next MISO bit on the falling edge, reload after a full byte
	always @(negedge spi_clk_i) begin
		if (!spi_cs_n_i) begin
			if (bit_cnt == 3'd0) begin
				tx_shift <= last_q;
			end else begin
				tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

endmodule

// File: hdl/spi_core_pkg.sv
// Constants and types of the SPI shift datapath.
// Shared by the register block, the shift engine, the receive holder
// and the top level.

package spi_core_pkg;

	// ----------------------------------------
	// Clock divider
	// ----------------------------------------
	localparam int DIVIDER_WIDTH = 16;
	localparam logic [DIVIDER_WIDTH-1:0] DIVIDER_INIT = 16'd100;

	// Bits per transfer
	localparam int SPI_BITS = 8;

	// ----------------------------------------
	// Shift engine states
	// ----------------------------------------
	// LEAD is the spi_clk low half, TRAIL the high half
	typedef enum logic [1:0] {
		IDLE,
		LEAD,
		TRAIL
	} shift_state_e;

endpackage

// File: hdl/spi_master.sv
// Memory-mapped SPI master for a soft-core processor system.
// Wishbone register block, mode 0 shift engine and receive holder.
// Connect the Wishbone slave port to the processor bus and the SPI pins
// to one slave device.

module spi_master
	import spi_reg_pkg::*, spi_core_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [WB_ADR_WIDTH-1:0] wb_adr_i,
	input  logic [WB_DAT_WIDTH-1:0] wb_dat_i,
	input  logic                    wb_we_i,
	input  logic [WB_SEL_WIDTH-1:0] wb_sel_i,
	input  logic                    wb_stb_i,
	output logic [WB_DAT_WIDTH-1:0] wb_dat_o,
	output logic                    wb_ack_o,
	output logic                    spi_cs_n_o,
	output logic                    spi_clk_o,
	output logic                    spi_mosi_o,
	input  logic                    spi_miso_i,
	output logic                    irq_o
);

	logic [DIVIDER_WIDTH-1:0] divider;
	logic                     tx_start;
	logic [SPI_BITS-1:0]      tx_data;
	logic                     busy;
	logic                     rx_valid;
	logic [SPI_BITS-1:0]      rx_data;
	logic                     rx_read;
	logic [SPI_BITS-1:0]      rx_byte;
	logic                     rx_full;

	// ----------------------------------------
	// Bus side
	// ----------------------------------------
	spi_wb_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_we_i    (wb_we_i),
		.wb_sel_i   (wb_sel_i),
		.wb_stb_i   (wb_stb_i),
		.busy_i     (busy),
		.rx_byte_i  (rx_byte),
		.rx_full_i  (rx_full),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.spi_cs_n_o (spi_cs_n_o),
		.divider_o  (divider),
		.tx_start_o (tx_start),
		.tx_data_o  (tx_data),
		.rx_read_o  (rx_read)
	);

	// Shift engine
	spi_shift_engine u_engine (
		.clk        (clk),
		.reset      (reset),
		.divider_i  (divider),
		.tx_start_i (tx_start),
		.tx_data_i  (tx_data),
		.spi_miso_i (spi_miso_i),
		.spi_clk_o  (spi_clk_o),
		.spi_mosi_o (spi_mosi_o),
		.busy_o     (busy),
		.rx_valid_o (rx_valid),
		.rx_data_o  (rx_data)
	);

	// Receive side and interrupt
	spi_rx_holder u_rx (
		.clk        (clk),
		.reset      (reset),
		.rx_valid_i (rx_valid),
		.rx_data_i  (rx_data),
		.rx_read_i  (rx_read),
		.rx_byte_o  (rx_byte),
		.rx_full_o  (rx_full),
		.irq_o      (irq_o)
	);

endmodule

// File: hdl/spi_reg_pkg.sv
// Register map and Wishbone bus widths of the SPI master.
// Imported by the register block, the top level and the testbench.

package spi_reg_pkg;

	// ----------------------------------------
	// Wishbone bus widths
	// ----------------------------------------
	localparam int WB_ADR_WIDTH = 3;
	localparam int WB_DAT_WIDTH = 32;
	localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;

	// ----------------------------------------
	// Register addresses
	// ----------------------------------------
	// Addresses 5 to 7 are unmapped and read as zero
	typedef enum logic [WB_ADR_WIDTH-1:0] {
		STATUS  = 3'd0,
		CONTROL = 3'd1,
		SEND    = 3'd2,
		RECV    = 3'd3,
		DIVIDER = 3'd4
	} spi_reg_e;

endpackage

// File: hdl/spi_rx_holder.sv
// Receive holder of the SPI master.
// Keeps the last received byte, sets rx_full when a byte arrives and
// clears it when software reads RECV. The interrupt follows rx_full.

module spi_rx_holder
	import spi_core_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                rx_valid_i,
	input  logic [SPI_BITS-1:0] rx_data_i,
	input  logic                rx_read_i,
	output logic [SPI_BITS-1:0] rx_byte_o,
	output logic                rx_full_o,
	output logic                irq_o
);

	logic [SPI_BITS-1:0] rx_byte_q;
	logic                rx_full_q;

	// A new byte simply overwrites the old one
	always_ff @(posedge clk) begin
		if (rx_valid_i) begin
			rx_byte_q <= rx_data_i;
		end
	end

	// Set has priority over the read clear
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_full_q <= 1'b0;
		end else if (rx_valid_i) begin
			rx_full_q <= 1'b1;
		end else if (rx_read_i) begin
			rx_full_q <= 1'b0;
		end
	end

	assign rx_byte_o = rx_byte_q;
	assign rx_full_o = rx_full_q;
	assign irq_o     = rx_full_q;

endmodule

// File: hdl/spi_shift_engine.sv
// SPI mode 0 shift engine, MSB first, one byte per transfer.
// A start pulse loads the byte; each half period of spi_clk lasts
// divider plus 1 clock cycles. MOSI is presented while spi_clk is low,
// MISO is sampled as spi_clk rises and the register shifts as it falls.
// rx_valid pulses for one cycle as busy drops.

module spi_shift_engine
	import spi_core_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [DIVIDER_WIDTH-1:0] divider_i,
	input  logic                     tx_start_i,
	input  logic [SPI_BITS-1:0]      tx_data_i,
	input  logic                     spi_miso_i,
	output logic                     spi_clk_o,
	output logic                     spi_mosi_o,
	output logic                     busy_o,
	output logic                     rx_valid_o,
	output logic [SPI_BITS-1:0]      rx_data_o
);

	shift_state_e                state;
	logic [DIVIDER_WIDTH-1:0]    div_cnt;
	logic [$clog2(SPI_BITS)-1:0] bit_cnt;
	logic [SPI_BITS-1:0]         shift_q;
	logic                        miso_q;
	logic                        sclk_q;
	logic                        rx_valid_q;
	logic                        half_done;
	logic                        last_bit;

	// Divider counter runs down to zero in every half period
	assign half_done = (div_cnt == '0);
	assign last_bit  = (bit_cnt == ($clog2(SPI_BITS))'(SPI_BITS - 1));

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			sclk_q     <= 1'b0;
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0;
			case (state)
				IDLE: begin
					if (tx_start_i) begin
						state   <= LEAD;
						div_cnt <= divider_i;
						bit_cnt <= '0;
					end
				end
				LEAD: begin
					if (half_done) begin
						// Rising edge of spi_clk
						state   <= TRAIL;
						div_cnt <= divider_i;
						sclk_q  <= 1'b1;
					end else begin
						div_cnt <= div_cnt - 1'b1;
					end
				end
				TRAIL: begin
					if (half_done) begin
						// Falling edge of spi_clk
						sclk_q  <= 1'b0;
						div_cnt <= divider_i;
						if (last_bit) begin
							state      <= IDLE;
							rx_valid_q <= 1'b1;
						end else begin
							state   <= LEAD;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						div_cnt <= div_cnt - 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Shift datapath
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (tx_start_i) begin
			shift_q <= tx_data_i;
		end else if (state == TRAIL && half_done) begin
			shift_q <= {shift_q[SPI_BITS-2:0], miso_q};
		end
		// MISO captured on the rising edge, shifted in on the falling one
		if (state == LEAD && half_done) begin
			miso_q <= spi_miso_i;
		end
	end

	assign busy_o     = (state != IDLE);
	assign spi_clk_o  = sclk_q;
	assign spi_mosi_o = busy_o & shift_q[SPI_BITS-1];
	assign rx_valid_o = rx_valid_q;
	// After the last shift the register holds the received byte
	assign rx_data_o  = shift_q;

endmodule

// File: hdl/spi_wb_regs.sv
// Wishbone slave register block of the SPI master.
// Holds chip select and the clock divider, starts a transfer on a SEND
// write and returns status, received data and divider on reads.
// Every strobe is acknowledged in the same cycle.

module spi_wb_regs
	import spi_reg_pkg::*, spi_core_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [WB_ADR_WIDTH-1:0]  wb_adr_i,
	input  logic [WB_DAT_WIDTH-1:0]  wb_dat_i,
	input  logic                     wb_we_i,
	input  logic [WB_SEL_WIDTH-1:0]  wb_sel_i,
	input  logic                     wb_stb_i,
	input  logic                     busy_i,
	input  logic [SPI_BITS-1:0]      rx_byte_i,
	input  logic                     rx_full_i,
	output logic [WB_DAT_WIDTH-1:0]  wb_dat_o,
	output logic                     wb_ack_o,
	output logic                     spi_cs_n_o,
	output logic [DIVIDER_WIDTH-1:0] divider_o,
	output logic                     tx_start_o,
	output logic [SPI_BITS-1:0]      tx_data_o,
	output logic                     rx_read_o
);

	spi_reg_e                 reg_addr;
	logic                     wr_en;
	logic                     rd_en;
	logic                     cs_n_q;
	logic [DIVIDER_WIDTH-1:0] divider_q;

	assign reg_addr = spi_reg_e'(wb_adr_i);
	assign wr_en    = wb_stb_i & wb_we_i;
	assign rd_en    = wb_stb_i & ~wb_we_i;

	// ----------------------------------------
	// Control and divider registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cs_n_q    <= 1'b1;
			divider_q <= DIVIDER_INIT;
		end else if (wr_en) begin
			if (reg_addr == CONTROL && wb_sel_i[0]) begin
				cs_n_q <= wb_dat_i[0];
			end
			if (reg_addr == DIVIDER) begin
				// Byte lanes of the divider follow the select bits
				for (int b = 0; b < DIVIDER_WIDTH / 8; b++) begin
					if (wb_sel_i[b]) begin
						divider_q[b*8 +: 8] <= wb_dat_i[b*8 +: 8];
					end
				end
			end
		end
	end

	assign spi_cs_n_o = cs_n_q;
	assign divider_o  = divider_q;

	// A SEND while the engine is busy gets no start pulse
	assign tx_start_o = wr_en & wb_sel_i[0] & (reg_addr == SEND) & ~busy_i;
	assign tx_data_o  = wb_dat_i[SPI_BITS-1:0];

	// Reading RECV hands the byte over and clears rx_full
	assign rx_read_o = rd_en & (reg_addr == RECV);

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb begin
		wb_dat_o = '0;
		case (reg_addr)
			STATUS: begin
				wb_dat_o[0] = busy_i;
				wb_dat_o[1] = rx_full_i;
			end
			CONTROL: wb_dat_o[0] = cs_n_q;
			RECV:    wb_dat_o[SPI_BITS-1:0] = rx_byte_i;
			DIVIDER: wb_dat_o[DIVIDER_WIDTH-1:0] = divider_q;
			default: wb_dat_o = '0;
		endcase
	end

	// No wait states
	assign wb_ack_o = wb_stb_i;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the SPI master testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f spi_master.f --top-module spi_master_tb

output="$(./obj_dir/Vspi_master_tb)"
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
	exit 0
fi
exit 1

// File: spi_master.f
hdl/spi_reg_pkg.sv
hdl/spi_core_pkg.sv
hdl/spi_wb_regs.sv
hdl/spi_shift_engine.sv
hdl/spi_rx_holder.sv
hdl/spi_master.sv
bench/spi_slave_model.sv
bench/spi_master_tb.sv
